/* axi_write_channel.sv */
`timescale 1ns/1ns
`default_nettype none

module axi_write_channel (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   empty,
    input  wt_cache_pkg::fe_addr_t head_addr,
    input  wt_cache_pkg::fe_data_t head_data,
    input  wt_cache_pkg::fe_strb_t head_strb,
    input  logic                   enable,
    input  wt_cache_pkg::retry_t   retry_limit,
    input  logic                   awready,
    input  logic                   wready,
    input  logic                   bvalid,
    input  logic [1:0]             bresp,
    output logic                   pop,
    output logic                   done,
    output logic                   retry,
    output logic                   abort,
    output logic                   awvalid,
    output wt_cache_pkg::be_addr_t awaddr,
    output logic                   wvalid,
    output wt_cache_pkg::be_data_t wdata,
    output wt_cache_pkg::be_strb_t wstrb,
    output logic                   wlast,
    output logic                   bready
);
    import wt_cache_pkg::*;

    wr_state_t state;
    fe_addr_t  ent_addr;
    fe_data_t  ent_data;
    fe_strb_t  ent_strb;
    retry_t    err_cnt;    // error responses seen for the current entry
    logic      b_hs;
    logic      b_ok;
    logic      can_retry;

    // take the head entry when idle and allowed
    assign pop = (state == wr_idle) && enable && !empty;

    assign awvalid = (state == wr_addr);
    assign wvalid  = (state == wr_data);
    assign wlast   = wvalid;   // single beat, awlen is zero
    assign bready  = (state == wr_resp);

    // beat formatting
    assign awaddr = {ent_addr[31:3], 3'b000};
    assign wdata  = {ent_data, ent_data};   // word in both halves
    assign wstrb  = ent_addr[2] ? {ent_strb, 4'b0000} : {4'b0000, ent_strb};

    assign b_hs      = bvalid && bready;
    assign b_ok      = (bresp == resp_okay);
    assign can_retry = (err_cnt < retry_limit);

    assign done  = b_hs && b_ok;
    assign retry = b_hs && !b_ok && can_retry;
    assign abort = b_hs && !b_ok && !can_retry;   // retries used up

    // popped entry, held across retries
    always_ff @(posedge clk) begin
        if (pop) begin
            ent_addr <= head_addr;
            ent_data <= head_data;
            ent_strb <= head_strb;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state   <= wr_idle;
            err_cnt <= '0;
        end else begin
            case (state)
                wr_idle: begin
                    if (pop) begin
                        state   <= wr_addr;
                        err_cnt <= '0;   // fresh entry
                    end
                end
                wr_addr: begin
                    if (awready)
                        state <= wr_data;
                end
                wr_data: begin
                    if (wready)
                        state <= wr_resp;
                end
                wr_resp: begin
                    if (b_hs) begin
                        if (b_ok) begin
                            state <= wr_idle;
                        end else if (can_retry) begin
                            state   <= wr_addr;   // same entry again
                            err_cnt <= err_cnt + 1'b1;
                        end else begin
                            state <= wr_idle;     // give the write up
                        end
                    end
                end
                default: state <= wr_idle;
            endcase
        end
    end

endmodule

`default_nettype wire

/* compile.f */
wt_cache_pkg.sv
write_buffer.sv
axi_write_channel.sv
write_ctrl_regs.sv
write_through_top.sv
write_through_props.sv
tb_write_through.sv

/* run_sim.sh */
#!/bin/sh
# build and run the write-through cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert --top-module tb_write_through \
    -f compile.f -o sim_write_through
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_write_through > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Some tests failed" "$log"; then
    echo "failure reported in $log"
    exit 1
fi

echo "no failure reported in $log"
exit 0

/* tb_write_through.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_write_through;
    import wt_cache_pkg::*;

    localparam int          clk_half    = 20;
    localparam int          drive_delay = 2;
    localparam int          step_limit  = 16;        // cycles for one handshake step
    localparam int          drain_limit = 3000;      // cycles
    localparam int          watchdog_ns = 2000000;
    localparam int unsigned seed        = 32'hf748;

    logic       clk;
    logic       reset;
    logic       wr_valid;
    fe_addr_t   wr_addr;
    fe_data_t   wr_data;
    fe_strb_t   wr_strb;
    logic       full;
    logic       reg_wr;
    logic       reg_rd;
    reg_addr_t  reg_addr;
    reg_data_t  reg_wdata;
    reg_data_t  reg_rdata;
    logic       reg_rvalid;
    logic       awvalid;
    be_addr_t   awaddr;
    logic       awready;
    logic       wvalid;
    be_data_t   wdata;
    be_strb_t   wstrb;
    logic       wlast;
    logic       wready;
    logic       bvalid;
    logic [1:0] bresp;
    logic       bready;

    // reference model state
    fe_addr_t    q_addr[$];
    fe_data_t    q_data[$];
    fe_strb_t    q_strb[$];
    be_data_t    exp_mem [be_addr_t];
    be_data_t    mem [be_addr_t];     // what the slave actually stored
    int unsigned exp_done;
    int unsigned exp_retry;
    int unsigned exp_abort;
    int unsigned exp_ovf;
    int unsigned model_err;          // errors seen for the head entry
    int unsigned cur_limit;
    int unsigned err_left;           // error responses still to give
    int unsigned errors;
    int unsigned timeouts;

    write_through_top i_dut (.*);

    initial begin : clock_gen
        clk = 1'b0;
        forever #clk_half clk = ~clk;
    end

    task automatic next_cycle;
        @(posedge clk);
        #drive_delay;
    endtask

    task automatic finish_run;
        $display("Errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    endtask

    task automatic timeout_exit(input string what);
        timeouts++;
        $display("Timeout while waiting for %s", what);
        finish_run();
    endtask

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] exp);
        errors++;
        $display("Error: %s = 0x%h, expected 0x%h", name, got, exp);
    endtask

    function automatic be_data_t model_beat(be_addr_t key);
        return exp_mem.exists(key) ? exp_mem[key] : '0;
    endfunction

    function automatic be_data_t slave_beat(be_addr_t key);
        return mem.exists(key) ? mem[key] : '0;
    endfunction

    // front-end word placed by address bit 2
    function automatic void model_store(fe_addr_t a, fe_data_t d, fe_strb_t s);
        be_addr_t key;
        be_data_t w;
        int       b;
        int       lane;
        key = {a[31:3], 3'b000};
        w   = model_beat(key);
        for (b = 0; b < 4; b++) begin
            lane = a[2] ? b + 4 : b;
            if (s[b])
                w[lane*8 +: 8] = d[b*8 +: 8];
        end
        exp_mem[key] = w;
    endfunction

    function automatic void slave_store(be_addr_t key, be_data_t d, be_strb_t s);
        be_data_t w;
        int       b;
        w = slave_beat(key);
        for (b = 0; b < 8; b++)
            if (s[b])
                w[b*8 +: 8] = d[b*8 +: 8];
        mem[key] = w;
    endfunction

    function automatic void drop_head;
        void'(q_addr.pop_front());
        void'(q_data.pop_front());
        void'(q_strb.pop_front());
        model_err = 0;
    endfunction

    function automatic void model_response(logic err);
        if (q_addr.size() == 0)
            return;
        if (!err) begin
            exp_done++;
            model_store(q_addr[0], q_data[0], q_strb[0]);
            drop_head();
        end else if (model_err < cur_limit) begin
            exp_retry++;   // same entry goes out again
            model_err++;
        end else begin
            exp_abort++;
            drop_head();
        end
    endfunction

    // one AW, W, B sequence with random ready delays
    task automatic serve_write;
        fe_addr_t a;
        fe_data_t d;
        fe_strb_t s;
        fe_data_t half;
        be_addr_t key;
        be_data_t beat;
        be_strb_t lanes;
        be_strb_t exp_strb;
        be_addr_t exp_addr;
        logic     err;
        int       n;
        a = '0;
        d = '0;
        s = '0;
        if (q_addr.size() == 0) begin
            errors++;
            $display("AXI write seen with no write left in the model queue");
        end else begin
            a = q_addr[0];
            d = q_data[0];
            s = q_strb[0];
        end
        exp_addr = a & ~32'h7;
        key = awaddr;
        if (awaddr !== exp_addr)
            report_mismatch("awaddr", 64'(awaddr), 64'(exp_addr));
        repeat ($urandom % 4)
            next_cycle;
        awready = 1'b1;
        next_cycle;
        awready = 1'b0;
        n = 0;
        while (!wvalid) begin
            if (n == step_limit)
                timeout_exit("wvalid");
            next_cycle;
            n++;
        end
        repeat ($urandom % 4)
            next_cycle;
        beat     = wdata;
        lanes    = wstrb;
        half     = a[2] ? wdata[63:32] : wdata[31:0];
        exp_strb = be_strb_t'(s) << (a[2] ? 4 : 0);
        if (wstrb !== exp_strb)
            report_mismatch("wstrb", 64'(wstrb), 64'(exp_strb));
        if (half !== d)
            report_mismatch(a[2] ? "wdata[63:32]" : "wdata[31:0]", 64'(half), 64'(d));
        if (wlast !== 1'b1)
            report_mismatch("wlast", 64'(wlast), 64'h1);
        wready = 1'b1;
        next_cycle;
        wready = 1'b0;
        n = 0;
        while (!bready) begin
            if (n == step_limit)
                timeout_exit("bready");
            next_cycle;
            n++;
        end
        repeat ($urandom % 4)
            next_cycle;
        err = (err_left != 0);
        if (err)
            err_left--;
        bresp  = err ? 2'b10 : resp_okay;   // SLVERR when chosen
        bvalid = 1'b1;
        @(posedge clk);                     // B handshake edge
        if (!err)
            slave_store(key, beat, lanes);
        model_response(err);
        #drive_delay;
        bvalid = 1'b0;
        bresp  = resp_okay;
    endtask

    initial begin : axi_slave
        awready = 1'b0;
        wready  = 1'b0;
        bvalid  = 1'b0;
        bresp   = resp_okay;
        forever begin
            next_cycle;
            if (!reset && awvalid)
                serve_write();
        end
    end

    initial begin : watchdog
        #(watchdog_ns);
        timeout_exit("the end of the run");
    end

    task automatic send_write(input fe_addr_t a, input fe_data_t d, input fe_strb_t s);
        if (full) begin
            exp_ovf++;   // buffer drops it
        end else begin
            q_addr.push_back(a);
            q_data.push_back(d);
            q_strb.push_back(s);
        end
        wr_valid = 1'b1;
        wr_addr  = a;
        wr_data  = d;
        wr_strb  = s;
        next_cycle;
        wr_valid = 1'b0;
    endtask

    function automatic fe_addr_t rand_addr;
        return 32'h1000 + (($urandom % 64) << 2);   // word in a 256-byte window
    endfunction

    task automatic write_reg(input reg_addr_t a, input reg_data_t d);
        reg_wr    = 1'b1;
        reg_addr  = a;
        reg_wdata = d;
        next_cycle;
        reg_wr = 1'b0;
    endtask

    task automatic set_ctrl(input logic [7:0] v);
        write_reg(reg_ctrl, {24'h0, v});
        cur_limit = int'(v[7:4]);
    endtask

    task automatic read_reg(input reg_addr_t a, output reg_data_t d);
        int n;
        reg_rd   = 1'b1;
        reg_addr = a;
        next_cycle;
        reg_rd = 1'b0;
        n = 0;
        while (!reg_rvalid) begin
            if (n == step_limit)
                timeout_exit("reg_rvalid");
            next_cycle;
            n++;
        end
        d = reg_rdata;
    endtask

    task automatic check_counter(input reg_addr_t a, input string name, input int unsigned exp);
        reg_data_t v;
        read_reg(a, v);
        if (v !== {16'h0, exp[15:0]})
            report_mismatch(name, 64'(v), 64'(exp[15:0]));
    endtask

    task automatic wait_drained;
        int n;
        n = 0;
        while (q_addr.size() != 0) begin
            if (n == drain_limit)
                timeout_exit("the write buffer to drain");
            next_cycle;
            n++;
        end
        repeat (2)
            next_cycle;
    endtask

    task automatic compare_memory;
        be_addr_t k;
        for (k = 32'h1000; k < 32'h1100; k += 8)
            if (slave_beat(k) !== model_beat(k))
                report_mismatch($sformatf("mem[0x%h]", k), slave_beat(k), model_beat(k));
    endtask

    initial begin : main
        reg_data_t prior;
        reg_data_t after;
        int        i;
        void'($urandom(seed));
        errors    = 0;
        timeouts  = 0;
        exp_done  = 0;
        exp_retry = 0;
        exp_abort = 0;
        exp_ovf   = 0;
        model_err = 0;
        err_left  = 0;
        cur_limit = 2;
        reset     = 1'b1;
        wr_valid  = 1'b0;
        wr_addr   = '0;
        wr_data   = '0;
        wr_strb   = '0;
        reg_wr    = 1'b0;
        reg_rd    = 1'b0;
        reg_addr  = '0;
        reg_wdata = '0;
        repeat (5)
            @(posedge clk);
        #drive_delay;
        reset = 1'b0;
        if ({awvalid, wvalid, bready, full, reg_rvalid} !== 5'b0)
            report_mismatch("{awvalid,wvalid,bready,full,reg_rvalid}",
                            64'({awvalid, wvalid, bready, full, reg_rvalid}), 64'h0);
        set_ctrl(8'h21);

        // random writes spaced wider than the mean drain time
        for (i = 0; i < 200; i++) begin
            send_write(rand_addr(), $urandom, 4'($urandom));
            repeat (8 + $urandom % 8)
                next_cycle;
        end
        wait_drained();
        compare_memory();
        check_counter(reg_done, "reg_done", 200);

        // 0 to 3 error responses per write with a limit of 2
        for (i = 0; i < 8; i++) begin
            err_left = i % 4;
            send_write(rand_addr(), $urandom, 4'hf);
            wait_drained();
        end
        compare_memory();
        check_counter(reg_retry, "reg_retry", exp_retry);
        check_counter(reg_abort, "reg_abort", exp_abort);
        check_counter(reg_done, "reg_done", exp_done);

        // channel held off while disabled
        set_ctrl(8'h20);
        for (i = 0; i < 5; i++)
            send_write(rand_addr(), $urandom, 4'($urandom));
        for (i = 0; i < 20; i++) begin
            if (awvalid) begin
                errors++;
                $display("awvalid rose while the channel was disabled");
            end
            next_cycle;
        end
        set_ctrl(8'h21);
        wait_drained();
        compare_memory();

        // overflow with full expected from the ninth write on
        set_ctrl(8'h20);
        for (i = 0; i < 12; i++) begin
            if (full !== (i >= 8))
                report_mismatch("full", 64'(full), 64'(i >= 8));
            send_write(rand_addr(), $urandom, 4'($urandom));
        end
        check_counter(reg_ovf, "reg_ovf", exp_ovf);
        set_ctrl(8'h21);
        wait_drained();
        compare_memory();
        check_counter(reg_done, "reg_done", exp_done);

        // register readback
        write_reg(reg_ctrl, 32'h0000_00a1);
        read_reg(reg_ctrl, after);
        if (after[7:0] !== 8'ha1)
            report_mismatch("reg_ctrl[7:0]", 64'(after[7:0]), 64'ha1);
        set_ctrl(8'h21);
        for (i = 1; i <= 4; i++) begin
            read_reg(reg_addr_t'(i), prior);
            write_reg(reg_addr_t'(i), $urandom);
            read_reg(reg_addr_t'(i), after);
            if (after !== prior)
                report_mismatch($sformatf("counter %0d", i), 64'(after), 64'(prior));
        end

        finish_run();
    end

endmodule

`default_nettype wire

/* write_buffer.sv */
`timescale 1ns/1ns
`default_nettype none

module write_buffer (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   wr_valid,
    input  wt_cache_pkg::fe_addr_t wr_addr,
    input  wt_cache_pkg::fe_data_t wr_data,
    input  wt_cache_pkg::fe_strb_t wr_strb,
    input  logic                   pop,
    output logic                   full,
    output logic                   empty,
    output logic                   ovf,
    output wt_cache_pkg::fe_addr_t head_addr,
    output wt_cache_pkg::fe_data_t head_data,
    output wt_cache_pkg::fe_strb_t head_strb
);
    import wt_cache_pkg::*;

    fe_addr_t mem_addr [buf_depth];
    fe_data_t mem_data [buf_depth];
    fe_strb_t mem_strb [buf_depth];

    logic [buf_ptr_w-1:0] wr_ptr;
    logic [buf_ptr_w-1:0] rd_ptr;
    logic [buf_ptr_w:0]   count;   // one extra bit to hold buf_depth
    logic                 do_push;
    logic                 do_pop;

    assign full  = (count == (buf_ptr_w + 1)'(buf_depth));
    assign empty = (count == '0);

    assign do_push = wr_valid && !full;
    assign do_pop  = pop && !empty;
    assign ovf     = wr_valid && full;   // dropped front-end write

    // head entry, meaningful only while not empty
    assign head_addr = mem_addr[rd_ptr];
    assign head_data = mem_data[rd_ptr];
    assign head_strb = mem_strb[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem_addr[wr_ptr] <= wr_addr;
            mem_data[wr_ptr] <= wr_data;
            mem_strb[wr_ptr] <= wr_strb;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;   // wraps at buf_depth
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;   // both or neither
            endcase
        end
    end

endmodule

`default_nettype wire

/* write_ctrl_regs.sv */
`timescale 1ns/1ns
`default_nettype none

module write_ctrl_regs (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    reg_wr,
    input  logic                    reg_rd,
    input  wt_cache_pkg::reg_addr_t reg_addr,
    input  wt_cache_pkg::reg_data_t reg_wdata,
    input  logic                    done,
    input  logic                    retry,
    input  logic                    abort,
    input  logic                    ovf,
    output wt_cache_pkg::reg_data_t reg_rdata,
    output logic                    reg_rvalid,
    output logic                    enable,
    output wt_cache_pkg::retry_t    retry_limit
);
    import wt_cache_pkg::*;

    logic [7:0] ctrl_q;
    count_t     done_cnt;
    count_t     retry_cnt;
    count_t     abort_cnt;
    count_t     ovf_cnt;
    reg_data_t  rd_mux;

    assign enable      = ctrl_q[0];
    assign retry_limit = ctrl_q[7:4];

    // only the control register is writable
    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            ctrl_q <= ctrl_rst;
        else if (reg_wr && reg_addr == reg_ctrl)
            ctrl_q <= reg_wdata[7:0];
    end

    // event counters, each wraps
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            done_cnt  <= '0;
            retry_cnt <= '0;
            abort_cnt <= '0;
            ovf_cnt   <= '0;
        end else begin
            if (done)
                done_cnt <= done_cnt + 1'b1;
            if (retry)
                retry_cnt <= retry_cnt + 1'b1;
            if (abort)
                abort_cnt <= abort_cnt + 1'b1;
            if (ovf)
                ovf_cnt <= ovf_cnt + 1'b1;
        end
    end

    always_comb begin
        case (reg_addr)
            reg_ctrl:  rd_mux = reg_data_t'(ctrl_q);
            reg_done:  rd_mux = reg_data_t'(done_cnt);
            reg_retry: rd_mux = reg_data_t'(retry_cnt);
            reg_abort: rd_mux = reg_data_t'(abort_cnt);
            reg_ovf:   rd_mux = reg_data_t'(ovf_cnt);
            default:   rd_mux = '0;   // unmapped index
        endcase
    end

    // read data one cycle after the strobe
    always_ff @(posedge clk) begin
        if (reg_rd)
            reg_rdata <= rd_mux;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            reg_rvalid <= 1'b0;
        else
            reg_rvalid <= reg_rd;
    end

endmodule

`default_nettype wire

/* write_through_props.sv */
`timescale 1ns/1ns
`default_nettype none

module write_through_props (
    input logic                   clk,
    input logic                   reset,
    input logic                   awvalid,
    input logic                   awready,
    input wt_cache_pkg::be_addr_t awaddr,
    input logic                   wvalid,
    input logic                   wready,
    input logic                   wlast,
    input logic                   pop,
    input logic                   empty
);

    a_aw_hold: assert property (@(posedge clk) disable iff (reset)
        awvalid && !awready |=> awvalid)
        else $error("awvalid dropped before awready");

    a_w_hold: assert property (@(posedge clk) disable iff (reset)
        wvalid && !wready |=> wvalid)
        else $error("wvalid dropped before wready");

    a_wlast: assert property (@(posedge clk) disable iff (reset) wlast == wvalid)
        else $error("wlast differs from wvalid");

    a_aw_align: assert property (@(posedge clk) disable iff (reset)
        awvalid |-> awaddr[2:0] == 3'b000)
        else $error("awaddr not aligned to 8 bytes");

    a_pop_empty: assert property (@(posedge clk) disable iff (reset) !(pop && empty))
        else $error("pop while the write buffer is empty");

endmodule

bind axi_write_channel write_through_props i_props (
    .clk     (clk),
    .reset   (reset),
    .awvalid (awvalid),
    .awready (awready),
    .awaddr  (awaddr),
    .wvalid  (wvalid),
    .wready  (wready),
    .wlast   (wlast),
    .pop     (pop),
    .empty   (empty)
);

`default_nettype wire

/* write_through_top.sv */
`timescale 1ns/1ns
`default_nettype none

module write_through_top (
    input  logic                    clk,
    input  logic                    reset,
    // front end
    input  logic                    wr_valid,
    input  wt_cache_pkg::fe_addr_t  wr_addr,
    input  wt_cache_pkg::fe_data_t  wr_data,
    input  wt_cache_pkg::fe_strb_t  wr_strb,
    output logic                    full,
    // register port
    input  logic                    reg_wr,
    input  logic                    reg_rd,
    input  wt_cache_pkg::reg_addr_t reg_addr,
    input  wt_cache_pkg::reg_data_t reg_wdata,
    output wt_cache_pkg::reg_data_t reg_rdata,
    output logic                    reg_rvalid,
    // AXI write
    output logic                    awvalid,
    output wt_cache_pkg::be_addr_t  awaddr,
    input  logic                    awready,
    output logic                    wvalid,
    output wt_cache_pkg::be_data_t  wdata,
    output wt_cache_pkg::be_strb_t  wstrb,
    output logic                    wlast,
    input  logic                    wready,
    input  logic                    bvalid,
    input  logic [1:0]              bresp,
    output logic                    bready
);
    import wt_cache_pkg::*;

    logic     empty;
    logic     ovf;
    logic     pop;
    logic     done;
    logic     retry;
    logic     abort;
    logic     enable;
    retry_t   retry_limit;
    fe_addr_t head_addr;
    fe_data_t head_data;
    fe_strb_t head_strb;

    write_buffer i_buffer (
        .clk       (clk),
        .reset     (reset),
        .wr_valid  (wr_valid),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .wr_strb   (wr_strb),
        .pop       (pop),
        .full      (full),
        .empty     (empty),
        .ovf       (ovf),
        .head_addr (head_addr),
        .head_data (head_data),
        .head_strb (head_strb)
    );

    axi_write_channel i_channel (
        .clk         (clk),
        .reset       (reset),
        .empty       (empty),
        .head_addr   (head_addr),
        .head_data   (head_data),
        .head_strb   (head_strb),
        .enable      (enable),
        .retry_limit (retry_limit),
        .awready     (awready),
        .wready      (wready),
        .bvalid      (bvalid),
        .bresp       (bresp),
        .pop         (pop),
        .done        (done),
        .retry       (retry),
        .abort       (abort),
        .awvalid     (awvalid),
        .awaddr      (awaddr),
        .wvalid      (wvalid),
        .wdata       (wdata),
        .wstrb       (wstrb),
        .wlast       (wlast),
        .bready      (bready)
    );

    write_ctrl_regs i_regs (
        .clk         (clk),
        .reset       (reset),
        .reg_wr      (reg_wr),
        .reg_rd      (reg_rd),
        .reg_addr    (reg_addr),
        .reg_wdata   (reg_wdata),
        .done        (done),
        .retry       (retry),
        .abort       (abort),
        .ovf         (ovf),
        .reg_rdata   (reg_rdata),
        .reg_rvalid  (reg_rvalid),
        .enable      (enable),
        .retry_limit (retry_limit)
    );

endmodule

`default_nettype wire

/* wt_cache_pkg.sv */
`default_nettype none

package wt_cache_pkg;

    // front-end side of the cache
    typedef logic [31:0] fe_addr_t;   // byte address
    typedef logic [31:0] fe_data_t;
    typedef logic [3:0]  fe_strb_t;

    // backend AXI side
    typedef logic [31:0] be_addr_t;   // always 8-byte aligned
    typedef logic [63:0] be_data_t;
    typedef logic [7:0]  be_strb_t;

    // write buffer geometry
    localparam int buf_depth = 8;
    localparam int buf_ptr_w = 3;

    typedef logic [3:0]  retry_t;
    typedef logic [15:0] count_t;     // wraps
    typedef logic [2:0]  reg_addr_t;
    typedef logic [31:0] reg_data_t;

    // register indices
    localparam reg_addr_t reg_ctrl  = 3'd0;
    localparam reg_addr_t reg_done  = 3'd1;
    localparam reg_addr_t reg_retry = 3'd2;
    localparam reg_addr_t reg_abort = 3'd3;
    localparam reg_addr_t reg_ovf   = 3'd4;

    // ctrl layout is enable in bit 0, retry limit in bits 7:4
    localparam logic [7:0] ctrl_rst = 8'h21;  // enabled, limit of 2

    localparam logic [1:0] resp_okay = 2'b00;

    typedef enum logic [1:0] {
        wr_idle,
        wr_addr,
        wr_data,
        wr_resp
    } wr_state_t;

endpackage

`default_nettype wire
